// ==== files.f ====
radio_regs_pkg.sv
radio_time_pkg.sv
settings_if.sv
settings_bus_decode.sv
radio_ctrl_regs.sv
timekeeper.sv
readback_mux.sv
radio_ctrl_top.sv
radio_ctrl_checker.sv
tb_clock_gen.sv
tb_radio_ctrl.sv

// ==== radio_ctrl_checker.sv ====
//////////////////////////////////////////////////
// Radio control assertions
// Wishbone ack rules and TX state after reset
//////////////////////////////////////////////////
`default_nettype none

module radio_ctrl_checker (
   input wire        bus_clk,
   input wire        i_reset,
   input wire        i_wb_cyc,
   input wire        i_wb_stb,
   input wire        o_wb_ack,
   input wire [31:0] o_tx
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;   // Assertion failures seen so far

   // Ack is a single cycle pulse
   ack_one_cycle: assert property (@(posedge bus_clk) disable iff (i_reset)
      o_wb_ack |=> !o_wb_ack)
      else begin
         fail_count++;
         $error("ack stayed high for more than one cycle");
      end

   // Every ack answers a request accepted one cycle earlier
   ack_after_stb: assert property (@(posedge bus_clk) disable iff (i_reset)
      o_wb_ack |-> $past(i_wb_cyc && i_wb_stb && !o_wb_ack))
      else begin
         fail_count++;
         $error("ack without an accepted request");
      end

   ack_in_cycle: assert property (@(posedge bus_clk) disable iff (i_reset)
      o_wb_ack |-> i_wb_cyc)
      else begin
         fail_count++;
         $error("ack while cyc is low");
      end

   // TX register comes out of reset at zero
   tx_reset_zero: assert property (@(posedge bus_clk)
      $fell(i_reset) |-> (o_tx == 32'd0))
      else begin
         fail_count++;
         $error("o_tx not zero after reset");
      end

endmodule

bind radio_ctrl_top radio_ctrl_checker u_checker (
   .bus_clk  (bus_clk),
   .i_reset  (i_reset),
   .i_wb_cyc (i_wb_cyc),
   .i_wb_stb (i_wb_stb),
   .o_wb_ack (o_wb_ack),
   .o_tx     (o_tx)
);

`default_nettype wire

// ==== radio_ctrl_regs.sv ====
//////////////////////////////////////////////////
// Radio control registers
// Setting registers, codec TX output register and
// digital loopback into the RX front end
//////////////////////////////////////////////////
`default_nettype none

module radio_ctrl_regs (
   input  wire                          bus_clk,
   input  wire                          i_reset,
   settings_if.sink                     set,
   input  wire radio_time_pkg::codec_word_t i_rx,
   output radio_time_pkg::codec_word_t  o_tx,
   output radio_regs_pkg::set_data_t    o_test,
   output radio_regs_pkg::rb_sel_t      o_rb_sel,
   output radio_regs_pkg::rb_word_t     o_codec,
   output radio_regs_pkg::rb_word_t     o_status
);

   logic                        loopback;
   logic                        run_tx;
   radio_time_pkg::codec_word_t tx_idle;
   radio_time_pkg::codec_word_t tx_sample;
   radio_time_pkg::codec_word_t rx_fe;

   //////////////////////////////////////////////////
   // Setting registers

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         loopback  <= 1'b0;
         o_test    <= '0;
         tx_idle   <= '0;
         o_rb_sel  <= '0;
         run_tx    <= 1'b0;
         tx_sample <= '0;
      end else if (set.set_stb) begin
         case (set.set_addr)
            radio_regs_pkg::SR_LOOPBACK:   loopback  <= set.set_data[0];
            radio_regs_pkg::SR_TEST:       o_test    <= set.set_data;
            radio_regs_pkg::SR_CODEC_IDLE: tx_idle   <= set.set_data;
            radio_regs_pkg::SR_READBACK:   o_rb_sel  <= set.set_data[2:0];
            radio_regs_pkg::SR_TX_CTRL:    run_tx    <= set.set_data[0];
            radio_regs_pkg::SR_TX_SAMPLE:  tx_sample <= set.set_data;
            default: ;   // Other blocks own the rest of the map
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Codec TX output

   // Idle word goes out whenever TX is not running
   always_ff @(posedge bus_clk) begin
      if (i_reset)
         o_tx <= '0;
      else
         o_tx <= run_tx ? tx_sample : tx_idle;
   end

   // Loopback replaces the codec RX input with TX
   assign rx_fe = loopback ? o_tx : i_rx;

   assign o_codec  = {o_tx, rx_fe};
   assign o_status = {62'd0, run_tx, loopback};

endmodule

`default_nettype wire

// ==== radio_ctrl_top.sv ====
//////////////////////////////////////////////////
// Radio control plane top level
// Wishbone slave, setting registers, timekeeper
// and readback on a single bus clock
//////////////////////////////////////////////////
`default_nettype none

module radio_ctrl_top (
   input  wire                              bus_clk,
   input  wire                              i_reset,
   // Wishbone classic slave
   input  wire                              i_wb_cyc,
   input  wire                              i_wb_stb,
   input  wire                              i_wb_we,
   input  wire radio_regs_pkg::set_addr_t   i_wb_adr,
   input  wire radio_regs_pkg::set_data_t   i_wb_dat,
   output radio_regs_pkg::set_data_t        o_wb_dat,
   output logic                             o_wb_ack,
   // Codec
   input  wire radio_time_pkg::codec_word_t i_rx,
   output radio_time_pkg::codec_word_t      o_tx,
   // Timing
   input  wire                              i_pps,
   output radio_time_pkg::vita_time_t       o_vita_time
);

   radio_regs_pkg::set_data_t  test_word;
   radio_regs_pkg::rb_sel_t    rb_sel;
   radio_regs_pkg::rb_word_t   codec_word;
   radio_regs_pkg::rb_word_t   status_word;
   radio_time_pkg::vita_time_t vita_time_pps;

   settings_if set_bus ();

   settings_bus_decode u_decode (
      .bus_clk  (bus_clk),
      .i_reset  (i_reset),
      .i_wb_cyc (i_wb_cyc),
      .i_wb_stb (i_wb_stb),
      .i_wb_we  (i_wb_we),
      .i_wb_adr (i_wb_adr),
      .i_wb_dat (i_wb_dat),
      .o_wb_dat (o_wb_dat),
      .o_wb_ack (o_wb_ack),
      .bus      (set_bus.master)
   );

   radio_ctrl_regs u_regs (
      .bus_clk  (bus_clk),
      .i_reset  (i_reset),
      .set      (set_bus.sink),
      .i_rx     (i_rx),
      .o_tx     (o_tx),
      .o_test   (test_word),
      .o_rb_sel (rb_sel),
      .o_codec  (codec_word),
      .o_status (status_word)
   );

   timekeeper u_timekeeper (
      .bus_clk         (bus_clk),
      .i_reset         (i_reset),
      .set             (set_bus.sink),
      .i_pps           (i_pps),
      .o_vita_time     (o_vita_time),
      .o_vita_time_pps (vita_time_pps)
   );

   readback_mux u_readback (
      .bus_clk         (bus_clk),
      .i_reset         (i_reset),
      .rb              (set_bus.reader),
      .i_rb_sel        (rb_sel),
      .i_test          (test_word),
      .i_vita_time     (o_vita_time),
      .i_vita_time_pps (vita_time_pps),
      .i_codec         (codec_word),
      .i_status        (status_word)
   );

endmodule

`default_nettype wire

// ==== radio_regs_pkg.sv ====
//////////////////////////////////////////////////
// Radio register map
// Setting addresses, readback slots and the
// widths used on the settings bus
//////////////////////////////////////////////////
`default_nettype none

package radio_regs_pkg;

   //////////////////////////////////////////////////
   // Register widths

   typedef logic [7:0]  set_addr_t;   // Setting address
   typedef logic [31:0] set_data_t;   // Setting and Wishbone data
   typedef logic [2:0]  rb_sel_t;     // Readback slot select
   typedef logic [63:0] rb_word_t;    // Full readback word

   //////////////////////////////////////////////////
   // Setting addresses

   // Front end and general
   localparam set_addr_t SR_LOOPBACK   = 8'd6;
   localparam set_addr_t SR_TEST       = 8'd21;
   localparam set_addr_t SR_CODEC_IDLE = 8'd22;
   localparam set_addr_t SR_READBACK   = 8'd32;

   // TX control
   localparam set_addr_t SR_TX_CTRL    = 8'd64;   // Bit 0 is run
   localparam set_addr_t SR_TX_SAMPLE  = 8'd65;

   // Timekeeper block
   localparam set_addr_t SR_TIME_HI    = 8'd128;
   localparam set_addr_t SR_TIME_LO    = 8'd129;
   localparam set_addr_t SR_TIME_CTRL  = 8'd130;

   //////////////////////////////////////////////////
   // Readback slots, 5 to 7 read zero

   localparam rb_sel_t RB_TEST     = 3'd0;
   localparam rb_sel_t RB_TIME     = 3'd1;
   localparam rb_sel_t RB_TIME_PPS = 3'd2;
   localparam rb_sel_t RB_CODEC    = 3'd3;   // {tx, rx front end}
   localparam rb_sel_t RB_STATUS   = 3'd4;   // {run, loopback} in low bits

endpackage

`default_nettype wire

// ==== radio_time_pkg.sv ====
//////////////////////////////////////////////////
// Radio time and codec definitions
// VITA time and sample word types, time control
// bit positions
//////////////////////////////////////////////////
`default_nettype none

package radio_time_pkg;

   // Free running VITA time, ticks of bus_clk
   typedef logic [63:0] vita_time_t;

   // Packed I/Q word, I in [31:16] and Q in [15:0]
   typedef logic [31:0] codec_word_t;

   //////////////////////////////////////////////////
   // Time control register bits

   localparam int TIME_CTRL_NOW = 0;   // Load pending time now
   localparam int TIME_CTRL_PPS = 1;   // Load at next PPS edge

endpackage

`default_nettype wire

// ==== readback_mux.sv ====
//////////////////////////////////////////////////
// Readback multiplexer
// Picks one of eight 64-bit slots and returns the
// requested 32-bit half on a read
//////////////////////////////////////////////////
`default_nettype none

module readback_mux (
   input  wire                             bus_clk,
   input  wire                             i_reset,
   settings_if.reader                      rb,
   input  wire radio_regs_pkg::rb_sel_t    i_rb_sel,
   input  wire radio_regs_pkg::set_data_t  i_test,
   input  wire radio_time_pkg::vita_time_t i_vita_time,
   input  wire radio_time_pkg::vita_time_t i_vita_time_pps,
   input  wire radio_regs_pkg::rb_word_t   i_codec,
   input  wire radio_regs_pkg::rb_word_t   i_status
);

   radio_regs_pkg::rb_word_t slot_word;
   radio_regs_pkg::rb_word_t held_word;   // Word of the last read
   radio_regs_pkg::rb_word_t rd_word;

   always_comb begin
      case (i_rb_sel)
         radio_regs_pkg::RB_TEST:     slot_word = {32'd0, i_test};
         radio_regs_pkg::RB_TIME:     slot_word = i_vita_time;
         radio_regs_pkg::RB_TIME_PPS: slot_word = i_vita_time_pps;
         radio_regs_pkg::RB_CODEC:    slot_word = i_codec;
         radio_regs_pkg::RB_STATUS:   slot_word = i_status;
         default:                     slot_word = '0;
      endcase
   end

   // Each read latches the slot as it stands
   always_ff @(posedge bus_clk) begin
      if (i_reset)
         held_word <= '0;
      else if (rb.rd_stb)
         held_word <= slot_word;
   end

   // Live slot during the read, last read word after it
   assign rd_word    = rb.rd_stb ? slot_word : held_word;
   assign rb.rd_data = rb.rd_hi ? rd_word[63:32] : rd_word[31:0];

endmodule

`default_nettype wire

// ==== settings_bus_decode.sv ====
//////////////////////////////////////////////////
// Wishbone settings slave
// Turns classic Wishbone cycles into setting
// strobes and readback requests, no wait states
//////////////////////////////////////////////////
`default_nettype none

module settings_bus_decode (
   input  wire                       bus_clk,
   input  wire                       i_reset,
   input  wire                       i_wb_cyc,
   input  wire                       i_wb_stb,
   input  wire                       i_wb_we,
   input  wire radio_regs_pkg::set_addr_t i_wb_adr,
   input  wire radio_regs_pkg::set_data_t i_wb_dat,
   output radio_regs_pkg::set_data_t o_wb_dat,
   output logic                      o_wb_ack,
   settings_if.master                bus
);

   logic accept;

   // New request only while ack is low, master drops stb after ack
   assign accept = i_wb_cyc && i_wb_stb && !o_wb_ack;

   //////////////////////////////////////////////////
   // Strobes and ack

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_wb_ack   <= 1'b0;
         bus.set_stb <= 1'b0;
         bus.rd_stb  <= 1'b0;
         bus.rd_hi   <= 1'b0;
      end else begin
         o_wb_ack    <= accept;
         bus.set_stb <= accept && i_wb_we;
         bus.rd_stb  <= accept && !i_wb_we;
         if (accept && !i_wb_we)
            bus.rd_hi <= i_wb_adr[0];   // Half select, other bits ignored
      end
   end

   // Write payload, only looked at with set_stb
   always_ff @(posedge bus_clk) begin
      if (accept && i_wb_we) begin
         bus.set_addr <= i_wb_adr;
         bus.set_data <= i_wb_dat;
      end
   end

   // Read data is valid during the ack cycle
   assign o_wb_dat = bus.rd_data;

endmodule

`default_nettype wire

// ==== settings_if.sv ====
//////////////////////////////////////////////////
// Settings bus
// Decoded writes and read requests between the
// bus slave and the register blocks
//////////////////////////////////////////////////
`default_nettype none

interface settings_if;

   // Write side, one cycle strobe
   logic                      set_stb;
   radio_regs_pkg::set_addr_t set_addr;
   radio_regs_pkg::set_data_t set_data;

   // Read side
   logic                      rd_stb;    // One cycle read pulse
   logic                      rd_hi;     // High half of readback word
   radio_regs_pkg::set_data_t rd_data;

   // Bus slave drives strobes, takes read data
   modport master (output set_stb, set_addr, set_data, rd_stb, rd_hi,
                   input  rd_data);

   // Register blocks decode set_addr themselves
   modport sink (input set_stb, set_addr, set_data);

   // Readback side
   modport reader (input rd_stb, rd_hi, output rd_data);

endinterface

`default_nettype wire

// ==== tb_clock_gen.sv ====
//////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns bus clock, reset held for five cycles
//////////////////////////////////////////////////
`default_nettype none

module tb_clock_gen (
   output logic bus_clk,
   output logic o_reset
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;
   end

   initial begin
      o_reset = 1'b1;
      repeat (5) @(posedge bus_clk);
      #1 o_reset = 1'b0;   // Release just after the edge
   end

endmodule

`default_nettype wire

// ==== tb_radio_ctrl.sv ====
//////////////////////////////////////////////////
// Radio control plane testbench
// Wishbone stimulus with a register model for the
// readback, TX, loopback and timekeeper behavior
//////////////////////////////////////////////////
`default_nettype none

module tb_radio_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   logic        bus_clk;
   logic        i_reset;
   logic        i_wb_cyc;
   logic        i_wb_stb;
   logic        i_wb_we;
   logic [7:0]  i_wb_adr;
   logic [31:0] i_wb_dat;
   wire  [31:0] o_wb_dat;
   wire         o_wb_ack;
   logic [31:0] i_rx;
   wire  [31:0] o_tx;
   logic        i_pps;
   wire  [63:0] o_vita_time;

   // Register model
   logic        m_loopback;
   logic        m_run;
   logic [31:0] m_test;
   logic [31:0] m_idle;
   logic [31:0] m_sample;

   integer      seed = 23;
   int          errors = 0;
   int          checks = 0;
   int          n;
   logic [31:0] hi_word;
   logic [63:0] w;
   logic [63:0] pend;
   logic [63:0] t_pre;
   logic [63:0] t_a;
   logic [63:0] t_b;

   tb_clock_gen u_clk (.bus_clk(bus_clk), .o_reset(i_reset));

   radio_ctrl_top u_radio_ctrl_top (
      .bus_clk     (bus_clk),
      .i_reset     (i_reset),
      .i_wb_cyc    (i_wb_cyc),
      .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),
      .i_wb_adr    (i_wb_adr),
      .i_wb_dat    (i_wb_dat),
      .o_wb_dat    (o_wb_dat),
      .o_wb_ack    (o_wb_ack),
      .i_rx        (i_rx),
      .o_tx        (o_tx),
      .i_pps       (i_pps),
      .o_vita_time (o_vita_time)
   );

   //////////////////////////////////////////////////
   // Reference model

   function automatic logic [31:0] expected_tx();
      return m_run ? m_sample : m_idle;   // Idle word unless running
   endfunction

   // Slots other than the two time slots
   function automatic logic [63:0] expected_slot(input logic [2:0] sel);
      logic [31:0] tx;
      tx = expected_tx();
      case (sel)
         radio_regs_pkg::RB_TEST:   return {32'd0, m_test};
         radio_regs_pkg::RB_CODEC:  return {tx, m_loopback ? tx : i_rx};
         radio_regs_pkg::RB_STATUS: return {62'd0, m_run, m_loopback};
         default:                   return 64'd0;
      endcase
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error: %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_range(input string name, input logic [63:0] got,
                              input logic [63:0] lo, input logic [63:0] hi);
      checks++;
      if (got < lo || got > hi) begin
         errors++;
         $display("Error: %s got 0x%h outside 0x%h to 0x%h", name, got, lo, hi);
      end
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Checks run: %0d, errors: %0d", checks, errors + 1);
      $display("Test failed");
      $finish;
   endtask

   //////////////////////////////////////////////////
   // Wishbone master

   task automatic wb_cycle(input logic we, input logic [7:0] adr,
                           input logic [31:0] dat, output logic [31:0] rdat);
      int cnt;
      @(posedge bus_clk);
      #1;
      i_wb_cyc = 1'b1;
      i_wb_stb = 1'b1;
      i_wb_we  = we;
      i_wb_adr = adr;
      i_wb_dat = dat;
      cnt = 0;
      @(negedge bus_clk);
      while (!o_wb_ack) begin
         cnt++;
         if (cnt == 20)
            abort_run("Wishbone ack did not arrive within 20 cycles");
         @(negedge bus_clk);
      end
      rdat = o_wb_dat;   // Valid during the ack cycle
      @(posedge bus_clk);
      #1;
      i_wb_cyc = 1'b0;
      i_wb_stb = 1'b0;
      i_wb_we  = 1'b0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] unused;
      wb_cycle(1'b1, addr, data, unused);
      case (addr)
         radio_regs_pkg::SR_LOOPBACK:   m_loopback = data[0];
         radio_regs_pkg::SR_TEST:       m_test     = data;
         radio_regs_pkg::SR_CODEC_IDLE: m_idle     = data;
         radio_regs_pkg::SR_TX_CTRL:    m_run      = data[0];
         radio_regs_pkg::SR_TX_SAMPLE:  m_sample   = data;
         default: ;
      endcase
   endtask

   // High half first, then low half of the selected slot
   task automatic read_word(output logic [63:0] word);
      logic [31:0] hi;
      logic [31:0] lo;
      wb_cycle(1'b0, 8'd1, 32'd0, hi);
      wb_cycle(1'b0, 8'd0, 32'd0, lo);
      word = {hi, lo};
   endtask

   task automatic check_tx();
      repeat (2) @(posedge bus_clk);   // Register, then o_tx
      @(negedge bus_clk);
      check_value("o_tx", o_tx, expected_tx());
   endtask

   //////////////////////////////////////////////////
   // Stimulus

   initial begin
      i_wb_cyc   = 1'b0;
      i_wb_stb   = 1'b0;
      i_wb_we    = 1'b0;
      i_wb_adr   = 8'd0;
      i_wb_dat   = 32'd0;
      i_rx       = 32'd0;
      i_pps      = 1'b0;
      m_loopback = 1'b0;
      m_run      = 1'b0;
      m_test     = 32'd0;
      m_idle     = 32'd0;
      m_sample   = 32'd0;
      n = 0;
      while (i_reset !== 1'b0) begin
         n++;
         if (n == 20)
            abort_run("Reset was not released within 20 cycles");
         @(negedge bus_clk);
      end

      // Every slot but time reads zero after reset
      for (int s = 0; s < 8; s++) begin
         if (s != radio_regs_pkg::RB_TIME) begin
            reg_write(radio_regs_pkg::SR_READBACK, s);
            read_word(w);
            check_value($sformatf("o_wb_dat slot %0d", s), w, expected_slot(s));
         end
      end

      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TEST);
      repeat (8) begin
         reg_write(radio_regs_pkg::SR_TEST, $random(seed));
         read_word(w);
         check_value("o_wb_dat test", w, expected_slot(radio_regs_pkg::RB_TEST));
      end

      // TX output, idle then sample
      reg_write(radio_regs_pkg::SR_CODEC_IDLE, $random(seed));
      check_tx();
      reg_write(radio_regs_pkg::SR_TX_SAMPLE, $random(seed));
      reg_write(radio_regs_pkg::SR_TX_CTRL, 32'd1);
      check_tx();

      // Codec readback with and without loopback
      @(posedge bus_clk);
      #1;
      i_rx = $random(seed);
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_CODEC);
      read_word(w);
      check_value("o_wb_dat codec", w, expected_slot(radio_regs_pkg::RB_CODEC));
      reg_write(radio_regs_pkg::SR_LOOPBACK, 32'd1);
      read_word(w);
      check_value("o_wb_dat loopback", w, expected_slot(radio_regs_pkg::RB_CODEC));
      reg_write(radio_regs_pkg::SR_TX_CTRL, 32'd0);
      check_tx();

      // Status word in both run and loopback states
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_STATUS);
      read_word(w);
      check_value("o_wb_dat status", w, expected_slot(radio_regs_pkg::RB_STATUS));
      reg_write(radio_regs_pkg::SR_TX_CTRL, 32'd1);
      reg_write(radio_regs_pkg::SR_LOOPBACK, 32'd0);
      read_word(w);
      check_value("o_wb_dat status", w, expected_slot(radio_regs_pkg::RB_STATUS));

      // Unused slots stay zero while the other slots are live
      for (int s = 5; s < 8; s++) begin
         reg_write(radio_regs_pkg::SR_READBACK, s);
         read_word(w);
         check_value($sformatf("o_wb_dat slot %0d", s), w, expected_slot(s));
      end

      //////////////////////////////////////////////////
      // Timekeeper

      hi_word = $random(seed) & 32'h7fff_ffff;   // Room for hi_word + 1
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TIME);
      reg_write(radio_regs_pkg::SR_TIME_HI, hi_word);
      reg_write(radio_regs_pkg::SR_TIME_LO, 32'h0000_0100);
      reg_write(radio_regs_pkg::SR_TIME_CTRL, 32'd1 << radio_time_pkg::TIME_CTRL_NOW);
      read_word(w);
      check_value("o_wb_dat time high", w[63:32], hi_word);
      check_range("o_wb_dat time low", w[31:0], 64'h101, 64'h10a);

      // Arm a load at the next PPS
      pend = {hi_word + 32'd1, 32'h0000_1000};
      reg_write(radio_regs_pkg::SR_TIME_HI, pend[63:32]);
      reg_write(radio_regs_pkg::SR_TIME_LO, pend[31:0]);
      reg_write(radio_regs_pkg::SR_TIME_CTRL, 32'd1 << radio_time_pkg::TIME_CTRL_PPS);
      read_word(t_pre);
      i_pps = 1'b1;
      n = 0;
      @(negedge bus_clk);
      while (o_vita_time < pend) begin
         n++;
         if (n == 20)
            abort_run("Time was not loaded within 20 cycles of the PPS pulse");
         @(negedge bus_clk);
      end
      check_value("o_vita_time", o_vita_time, pend);   // First cycle after the load
      read_word(t_a);
      i_pps = 1'b0;
      check_range("o_wb_dat time after PPS", t_a, pend, pend + 64'd19);
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TIME_PPS);
      read_word(t_b);
      check_range("o_wb_dat PPS time", t_b, t_pre, pend - 64'd1);

      // Second PPS captures without a load
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TIME);
      read_word(t_a);
      i_pps = 1'b1;
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TIME_PPS);
      pend = t_b;   // Capture of the first PPS
      n = 0;
      read_word(t_b);
      while (t_b == pend) begin
         n++;
         if (n == 10)
            abort_run("Second PPS capture did not appear within 10 reads");
         read_word(t_b);
      end
      i_pps = 1'b0;
      reg_write(radio_regs_pkg::SR_READBACK, radio_regs_pkg::RB_TIME);
      read_word(w);
      check_range("o_wb_dat second PPS time", t_b, t_a, w);

      errors += u_radio_ctrl_top.u_checker.fail_count;
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== timekeeper.sv ====
//////////////////////////////////////////////////
// VITA timekeeper
// 64-bit time counter, set now or at next PPS,
// and time capture at each PPS edge
//////////////////////////////////////////////////
`default_nettype none

module timekeeper (
   input  wire                        bus_clk,
   input  wire                        i_reset,
   settings_if.sink                   set,
   input  wire                        i_pps,
   output radio_time_pkg::vita_time_t o_vita_time,
   output radio_time_pkg::vita_time_t o_vita_time_pps
);

   logic                      pps_s1;
   logic                      pps_s2;
   logic                      pps_d;
   logic                      pps_edge;
   logic                      pps_armed;    // Set-at-PPS pending
   logic                      ctrl_wr;
   radio_regs_pkg::set_data_t pend_hi;
   radio_regs_pkg::set_data_t pend_lo;

   //////////////////////////////////////////////////
   // PPS synchronizer and rising edge detect

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
      end else begin
         pps_s1 <= i_pps;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
      end
   end

   assign pps_edge = pps_s2 && !pps_d;

   // Pending time words
   always_ff @(posedge bus_clk) begin
      if (set.set_stb && set.set_addr == radio_regs_pkg::SR_TIME_HI)
         pend_hi <= set.set_data;
      if (set.set_stb && set.set_addr == radio_regs_pkg::SR_TIME_LO)
         pend_lo <= set.set_data;
   end

   assign ctrl_wr = set.set_stb && (set.set_addr == radio_regs_pkg::SR_TIME_CTRL);

   //////////////////////////////////////////////////
   // Time counter

   always_ff @(posedge bus_clk) begin
      if (i_reset) begin
         o_vita_time     <= '0;
         o_vita_time_pps <= '0;
         pps_armed       <= 1'b0;
      end else begin
         if (ctrl_wr && set.set_data[radio_time_pkg::TIME_CTRL_NOW])
            o_vita_time <= {pend_hi, pend_lo};
         else if (pps_edge && pps_armed)
            o_vita_time <= {pend_hi, pend_lo};
         else
            o_vita_time <= o_vita_time + 64'd1;

         if (pps_edge)
            o_vita_time_pps <= o_vita_time;   // Time before any load

         // A control write replaces the armed state
         if (ctrl_wr)
            pps_armed <= set.set_data[radio_time_pkg::TIME_CTRL_PPS];
         else if (pps_edge)
            pps_armed <= 1'b0;
      end
   end

endmodule

`default_nettype wire
